// ==== design/tester_params.svh ====
`ifndef TESTER_PARAMS_SVH
`define TESTER_PARAMS_SVH

// --------------------------------------------------
// Shared memory geometry
// --------------------------------------------------

// Word address width, 256 words by default
`define TESTER_ADDR_W 8

// Data word width
`define TESTER_DATA_W 32

// --------------------------------------------------
// Reset release
// --------------------------------------------------

// Cycles from all reset conditions good to sys_reset low
`define TESTER_RST_STAGES 2

`endif

// ==== design/tester_pkg.sv ====
`default_nettype none

`include "tester_params.svh"

package tester_pkg;

   // --------------------------------------------------
   // Shared memory word types
   // --------------------------------------------------

   typedef logic [`TESTER_ADDR_W-1:0] mem_addr_t; // Word address
   typedef logic [`TESTER_DATA_W-1:0] mem_data_t; // Data word

   // --------------------------------------------------
   // Requester identifiers
   // --------------------------------------------------

   // Used for the grant output and the first-trap record
   typedef enum logic [1:0] {
      PORT_NONE   = 2'd0,
      PORT_TESTER = 2'd1,
      PORT_UUT    = 2'd2
   } port_id_t;

endpackage

`default_nettype wire

// ==== design/reset_sync.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "tester_params.svh"

module reset_sync (
   input  logic clk,
   input  logic reset,
   input  logic pll_locked,
   input  logic mem_init_done,
   output logic sys_reset,
   output logic ready
);

   localparam int STAGES = `TESTER_RST_STAGES;

   logic              rst_req;
   logic [STAGES-1:0] release_q; // Fills with ones after release

   // Any one of the three holds the system in reset
   assign rst_req = reset | ~pll_locked | ~mem_init_done;

   always_ff @(posedge clk) begin
      if (rst_req) begin
         release_q <= '0;
      end else begin
         release_q <= (release_q << 1) | STAGES'(1);
      end
   end

   // Asserted at once, released only when the chain is full
   assign sys_reset = rst_req | ~release_q[STAGES-1];
   assign ready     = ~sys_reset;

endmodule

`default_nettype wire

// ==== design/mem_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter (
   input  logic                  clk,
   input  logic                  sys_reset,
   // Tester port
   input  logic                  t_req,
   input  logic                  t_we,
   input  tester_pkg::mem_addr_t t_addr,
   input  tester_pkg::mem_data_t t_wdata,
   output tester_pkg::mem_data_t t_rdata,
   output logic                  t_ack,
   // UUT port
   input  logic                  u_req,
   input  logic                  u_we,
   input  tester_pkg::mem_addr_t u_addr,
   input  tester_pkg::mem_data_t u_wdata,
   output tester_pkg::mem_data_t u_rdata,
   output logic                  u_ack,
   // Shared memory side
   output logic                  mem_en,
   output logic                  mem_we,
   output tester_pkg::mem_addr_t mem_addr,
   output tester_pkg::mem_data_t mem_wdata,
   input  tester_pkg::mem_data_t mem_rdata,
   output tester_pkg::port_id_t  grant
);

   import tester_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ACCESS,
      ST_RESPOND
   } arb_state_t;

   arb_state_t state_q, state_d;
   port_id_t   owner_q;     // Port holding the memory
   port_id_t   sel;
   logic       prio_uut_q;  // UUT wins the next tie
   logic       cand_t, cand_u;
   logic       start;

   logic       lat_we_q;
   mem_addr_t  lat_addr_q;
   mem_data_t  lat_wdata_q;

   // --------------------------------------------------
   // Port selection
   // --------------------------------------------------

   always_comb begin
      // A port is not sampled during its own ack cycle
      cand_t = t_req && !(state_q == ST_RESPOND && owner_q == PORT_TESTER);
      cand_u = u_req && !(state_q == ST_RESPOND && owner_q == PORT_UUT);
      if (cand_t && cand_u) begin
         sel = prio_uut_q ? PORT_UUT : PORT_TESTER;
      end else if (cand_t) begin
         sel = PORT_TESTER;
      end else if (cand_u) begin
         sel = PORT_UUT;
      end else begin
         sel = PORT_NONE;
      end
      start = (state_q != ST_ACCESS) && (sel != PORT_NONE);
   end

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE:    if (start) state_d = ST_ACCESS;
         ST_ACCESS:  state_d = ST_RESPOND;               // One memory strobe
         ST_RESPOND: state_d = start ? ST_ACCESS : ST_IDLE;
         default:    state_d = ST_IDLE;
      endcase
   end

   // --------------------------------------------------
   // Control and request latch
   // --------------------------------------------------

   always_ff @(posedge clk) begin
      if (sys_reset) begin
         state_q    <= ST_IDLE;
         owner_q    <= PORT_NONE;
         prio_uut_q <= 1'b0;           // Tester first
      end else begin
         state_q <= state_d;
         if (start) begin
            owner_q    <= sel;
            prio_uut_q <= (sel == PORT_TESTER); // Other side wins next
         end else if (state_q == ST_RESPOND) begin
            owner_q <= PORT_NONE;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         lat_we_q    <= (sel == PORT_UUT) ? u_we    : t_we;
         lat_addr_q  <= (sel == PORT_UUT) ? u_addr  : t_addr;
         lat_wdata_q <= (sel == PORT_UUT) ? u_wdata : t_wdata;
      end
   end

   assign mem_en    = (state_q == ST_ACCESS);
   assign mem_we    = lat_we_q;
   assign mem_addr  = lat_addr_q;
   assign mem_wdata = lat_wdata_q;

   assign t_ack   = (state_q == ST_RESPOND) && (owner_q == PORT_TESTER);
   assign u_ack   = (state_q == ST_RESPOND) && (owner_q == PORT_UUT);
   assign t_rdata = mem_rdata; // Valid while t_ack
   assign u_rdata = mem_rdata; // Valid while u_ack
   assign grant   = owner_q;

endmodule

`default_nettype wire

// ==== design/shared_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

module shared_mem (
   input  logic                  clk,
   input  logic                  mem_en,
   input  logic                  mem_we,
   input  tester_pkg::mem_addr_t mem_addr,
   input  tester_pkg::mem_data_t mem_wdata,
   output tester_pkg::mem_data_t mem_rdata
);

   import tester_pkg::*;

   // One word per address value
   localparam int DEPTH = 2 ** $bits(mem_addr_t);

   // --------------------------------------------------
   // Storage
   // --------------------------------------------------

   mem_data_t mem_array [DEPTH];
   mem_data_t rdata_q;

   // Write strobe
   always_ff @(posedge clk) begin
      if (mem_en && mem_we) begin
         mem_array[mem_addr] <= mem_wdata;
      end
   end

   // Registered read, holds its value on writes and idle cycles
   always_ff @(posedge clk) begin
      if (mem_en && !mem_we) begin
         rdata_q <= mem_array[mem_addr];
      end
   end

   assign mem_rdata = rdata_q;

endmodule

`default_nettype wire

// ==== design/trap_monitor.sv ====
`timescale 1ns/10ps
`default_nettype none

module trap_monitor (
   input  logic                 clk,
   input  logic                 sys_reset,
   input  logic                 trap_tester,
   input  logic                 trap_uut,
   output logic                 trap,
   output tester_pkg::port_id_t trap_first
);

   import tester_pkg::*;

   logic     tester_seen_q;
   logic     uut_seen_q;
   port_id_t first_q;

   // --------------------------------------------------
   // Sticky flags
   // --------------------------------------------------

   always_ff @(posedge clk) begin
      if (sys_reset) begin
         tester_seen_q <= 1'b0;
         uut_seen_q    <= 1'b0;
         first_q       <= PORT_NONE;
      end else begin
         if (trap_tester) tester_seen_q <= 1'b1;
         if (trap_uut) uut_seen_q <= 1'b1;
         // Captured once, tester wins a tie
         if (first_q == PORT_NONE) begin
            if (trap_tester) begin
               first_q <= PORT_TESTER;
            end else if (trap_uut) begin
               first_q <= PORT_UUT;
            end
         end
      end
   end

   assign trap       = tester_seen_q | uut_seen_q;
   assign trap_first = first_q;

endmodule

`default_nettype wire

// ==== design/top_system.sv ====
`timescale 1ns/10ps
`default_nettype none

module top_system (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  pll_locked,
   input  logic                  mem_init_done,
   output logic                  ready,
   // Tester requester
   input  logic                  t_req,
   input  logic                  t_we,
   input  tester_pkg::mem_addr_t t_addr,
   input  tester_pkg::mem_data_t t_wdata,
   output tester_pkg::mem_data_t t_rdata,
   output logic                  t_ack,
   // UUT requester
   input  logic                  u_req,
   input  logic                  u_we,
   input  tester_pkg::mem_addr_t u_addr,
   input  tester_pkg::mem_data_t u_wdata,
   output tester_pkg::mem_data_t u_rdata,
   output logic                  u_ack,
   // Traps
   input  logic                  trap_tester,
   input  logic                  trap_uut,
   output logic                  trap,
   output tester_pkg::port_id_t  trap_first,
   output tester_pkg::port_id_t  grant
);

   import tester_pkg::*;

   logic      sys_reset;
   logic      mem_en;
   logic      mem_we;
   mem_addr_t mem_addr;
   mem_data_t mem_wdata;
   mem_data_t mem_rdata;

   // --------------------------------------------------
   // Reset
   // --------------------------------------------------

   reset_sync u_reset_sync (
      .clk           (clk),
      .reset         (reset),
      .pll_locked    (pll_locked),
      .mem_init_done (mem_init_done),
      .sys_reset     (sys_reset),
      .ready         (ready)
   );

   // --------------------------------------------------
   // Shared memory path
   // --------------------------------------------------

   mem_arbiter u_mem_arbiter (
      .clk       (clk),
      .sys_reset (sys_reset),
      .t_req     (t_req),
      .t_we      (t_we),
      .t_addr    (t_addr),
      .t_wdata   (t_wdata),
      .t_rdata   (t_rdata),
      .t_ack     (t_ack),
      .u_req     (u_req),
      .u_we      (u_we),
      .u_addr    (u_addr),
      .u_wdata   (u_wdata),
      .u_rdata   (u_rdata),
      .u_ack     (u_ack),
      .mem_en    (mem_en),
      .mem_we    (mem_we),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_rdata (mem_rdata),
      .grant     (grant)
   );

   shared_mem u_shared_mem (
      .clk       (clk),
      .mem_en    (mem_en),
      .mem_we    (mem_we),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_rdata (mem_rdata)
   );

   // Both trap sources into one sticky output
   trap_monitor u_trap_monitor (
      .clk         (clk),
      .sys_reset   (sys_reset),
      .trap_tester (trap_tester),
      .trap_uut    (trap_uut),
      .trap        (trap),
      .trap_first  (trap_first)
   );

endmodule

`default_nettype wire

// ==== test/top_system_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

module top_system_chk (
   input logic clk,
   input logic sys_reset,
   input logic pll_locked,
   input logic ready,
   input logic t_req,
   input logic t_ack,
   input logic u_req,
   input logic u_ack,
   input logic trap
);

   int unsigned fail_count = 0; // Read by the testbench at the end
   int          t_wait;         // Cycles of open tester request
   int          u_wait;

   always_ff @(posedge clk) begin
      if (sys_reset) begin
         t_wait <= 0;
         u_wait <= 0;
      end else begin
         t_wait <= (t_req && !t_ack) ? t_wait + 1 : 0;
         u_wait <= (u_req && !u_ack) ? u_wait + 1 : 0;
      end
   end

   // --------------------------------------------------
   // Handshake
   // --------------------------------------------------

   a_one_ack: assert property (@(posedge clk) disable iff (sys_reset) !(t_ack && u_ack))
      else begin fail_count++; $error("Both ports acknowledged in one cycle"); end

   a_t_pulse: assert property (@(posedge clk) disable iff (sys_reset) t_ack |=> !t_ack)
      else begin fail_count++; $error("Tester ack held longer than one cycle"); end

   a_u_pulse: assert property (@(posedge clk) disable iff (sys_reset) u_ack |=> !u_ack)
      else begin fail_count++; $error("UUT ack held longer than one cycle"); end

   // Loser of a tie waits out one full transaction
   a_t_latency: assert property (@(posedge clk) disable iff (sys_reset) t_wait <= 4)
      else begin fail_count++; $error("Tester request not acknowledged in time"); end

   a_u_latency: assert property (@(posedge clk) disable iff (sys_reset) u_wait <= 4)
      else begin fail_count++; $error("UUT request not acknowledged in time"); end

   // --------------------------------------------------
   // Trap and reset
   // --------------------------------------------------

   a_trap_sticky: assert property (@(posedge clk) trap && !sys_reset |=> trap)
      else begin fail_count++; $error("Trap cleared without a reset"); end

   a_ready_lock: assert property (@(posedge clk) !pll_locked |-> !ready)
      else begin fail_count++; $error("Ready high while the clock is unlocked"); end

endmodule

bind top_system top_system_chk u_top_system_chk (
   .clk        (clk),
   .sys_reset  (sys_reset),
   .pll_locked (pll_locked),
   .ready      (ready),
   .t_req      (t_req),
   .t_ack      (t_ack),
   .u_req      (u_req),
   .u_ack      (u_ack),
   .trap       (trap)
);

`default_nettype wire

// ==== test/tb_top_system.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "tester_params.svh"

module tb_top_system;

   import tester_pkg::*;

   localparam int CLK_PERIOD = 40;
   localparam int N_RAND     = 8;                          // Words in the single-port test
   localparam int N_ROUNDS   = 4;                          // Contention rounds
   localparam int N_TRANS    = 2 * N_RAND + 4 + 4 * N_ROUNDS;

   logic      clk, reset, pll_locked, mem_init_done, ready;
   logic      t_req, t_we, t_ack, u_req, u_we, u_ack;
   mem_addr_t t_addr, u_addr;
   mem_data_t t_wdata, u_wdata, t_rdata, u_rdata;
   logic      trap_tester, trap_uut, trap;
   port_id_t  trap_first, grant;

   mem_data_t ref_mem [2**`TESTER_ADDR_W];  // Reference memory
   logic      ref_valid [2**`TESTER_ADDR_W];
   logic      prio_uut;                     // UUT wins the next tie
   integer    seed = 32'h7cb6;
   int        errors, checks, err_mark, tests_ok, tests_bad;
   string     cur_test;

   top_system u_top_system (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(CLK_PERIOD * (N_TRANS * 6 + 200));
      $display("Watchdog expired before the tests finished");
      $display("TESTBENCH FAILED");
      $finish;
   end

   // --------------------------------------------------
   // Helpers
   // --------------------------------------------------

   task automatic compare_word(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
      checks++;
      assert (act === exp) else begin
         errors++;
         $display("Error %0s (%0s): expected %h, actual %h", cur_test, what, exp, act);
      end
   endtask

   // Compare failures plus bound assertion failures so far
   function automatic int fail_total();
      return errors + int'(u_top_system.u_top_system_chk.fail_count);
   endfunction

   task automatic start_test(input string name);
      cur_test = name;
      err_mark = fail_total();
   endtask

   task automatic end_test();
      logic clean;
      clean = (fail_total() == err_mark);
      if (clean) tests_ok++;
      else tests_bad++;
      $display("Test %0s: %0s", cur_test, clean ? "ok" : "errors found");
   endtask

   // One request on one port, lat counts cycles from sample to ack
   task automatic access_mem(input port_id_t port, input logic we, input mem_addr_t addr,
                             input mem_data_t wdata, output int lat);
      logic      ack_seen;
      mem_data_t rdata;
      @(posedge clk);
      #2;
      if (port == PORT_UUT) begin
         {u_req, u_we, u_addr, u_wdata} = {1'b1, we, addr, wdata};
      end else begin
         {t_req, t_we, t_addr, t_wdata} = {1'b1, we, addr, wdata};
      end
      lat = -1;
      ack_seen = 1'b0;
      while (!ack_seen) begin
         @(negedge clk);
         lat++;
         ack_seen = (port == PORT_UUT) ? u_ack : t_ack;
      end
      rdata = (port == PORT_UUT) ? u_rdata : t_rdata;
      compare_word("grant at ack", 32'(port), 32'(grant));
      if (we) begin
         ref_mem[addr] = wdata;
         ref_valid[addr] = 1'b1;
      end else if (ref_valid[addr]) begin
         compare_word("read data", ref_mem[addr], rdata);
      end
      prio_uut = (port == PORT_TESTER);  // Other side holds the next tie
      @(posedge clk);
      #2;
      if (port == PORT_UUT) u_req = 1'b0;
      else t_req = 1'b0;
   endtask

   task automatic request_both(input logic we, input mem_addr_t ta, input mem_addr_t ua);
      port_id_t  first;
      mem_data_t wd_t;
      mem_data_t wd_u;
      int        lat_t;
      int        lat_u;
      first = prio_uut ? PORT_UUT : PORT_TESTER;
      wd_t = $random(seed);
      wd_u = $random(seed);
      fork
         access_mem(PORT_TESTER, we, ta, wd_t, lat_t);
         access_mem(PORT_UUT, we, ua, wd_u, lat_u);
      join
      compare_word("first grant", 32'(first),
                   (lat_t < lat_u) ? 32'(PORT_TESTER) : 32'(PORT_UUT));
   endtask

   task automatic pulse_trap(input logic tst, input logic uut);
      @(posedge clk);
      #2;
      {trap_tester, trap_uut} = {tst, uut};
      @(posedge clk);
      #2;
      {trap_tester, trap_uut} = 2'b00;
      @(negedge clk);
   endtask

   // --------------------------------------------------
   // Test sequence
   // --------------------------------------------------

   initial begin
      int        lat;
      mem_addr_t addrs [N_RAND];
      mem_addr_t ta;
      {errors, checks, tests_ok, tests_bad} = '0;
      {reset, pll_locked, mem_init_done} = 3'b100;
      {t_req, t_we, t_addr, t_wdata, u_req, u_we, u_addr, u_wdata} = '0;
      {trap_tester, trap_uut} = 2'b00;
      prio_uut = 1'b0;
      for (int i = 0; i < 2**`TESTER_ADDR_W; i++) ref_valid[i] = 1'b0;
      repeat (4) @(posedge clk);
      #2;
      reset = 1'b0;

      start_test("reset gating");
      repeat (6) begin
         @(negedge clk);
         compare_word("ready without lock", 0, 32'(ready));
      end
      @(posedge clk);
      #2;
      {pll_locked, mem_init_done} = 2'b11;
      repeat (`TESTER_RST_STAGES) begin
         @(negedge clk);
         compare_word("ready during release", 0, 32'(ready));
      end
      repeat (4) begin
         @(negedge clk);
         compare_word("ready after release", 1, 32'(ready));
      end
      compare_word("acks idle", 0, 32'({t_ack, u_ack, trap}));
      compare_word("trap_first idle", 32'(PORT_NONE), 32'(trap_first));
      end_test();

      start_test("single port");
      for (int i = 0; i < N_RAND; i++) begin
         addrs[i] = mem_addr_t'($random(seed));
         access_mem(PORT_TESTER, 1'b1, addrs[i], $random(seed), lat);
         compare_word("write latency", 2, lat);
      end
      for (int i = 0; i < N_RAND; i++) begin
         access_mem(PORT_TESTER, 1'b0, addrs[i], '0, lat);
         compare_word("read latency", 2, lat);
      end
      end_test();

      start_test("shared visibility");
      ta = mem_addr_t'($random(seed));
      access_mem(PORT_TESTER, 1'b1, ta, $random(seed), lat);
      access_mem(PORT_UUT, 1'b0, ta, '0, lat);
      access_mem(PORT_UUT, 1'b1, ~ta, $random(seed), lat);
      access_mem(PORT_TESTER, 1'b0, ~ta, '0, lat);
      end_test();

      start_test("contention");
      for (int r = 0; r < N_ROUNDS; r++) begin
         ta = mem_addr_t'($random(seed));
         request_both(1'b1, ta, ~ta);
         request_both(1'b0, ~ta, ta);  // Each side reads the other's word
      end
      end_test();

      start_test("traps");
      pulse_trap(1'b0, 1'b1);
      compare_word("trap after uut", 1, 32'(trap));
      compare_word("first after uut", 32'(PORT_UUT), 32'(trap_first));
      pulse_trap(1'b1, 1'b0);
      repeat (3) @(negedge clk);
      compare_word("trap held", 1, 32'(trap));
      compare_word("first held", 32'(PORT_UUT), 32'(trap_first));
      @(posedge clk);
      #2;
      reset = 1'b1;
      repeat (4) @(posedge clk);
      #2;
      reset = 1'b0;
      prio_uut = 1'b0;
      do @(negedge clk); while (!ready);
      compare_word("trap after reset", 0, 32'(trap));
      compare_word("first after reset", 32'(PORT_NONE), 32'(trap_first));
      pulse_trap(1'b1, 1'b1);
      compare_word("trap after tie", 1, 32'(trap));
      compare_word("first after tie", 32'(PORT_TESTER), 32'(trap_first));
      end_test();

      $display("Summary: %0d tests ok, %0d with errors, %0d checks, %0d errors, %0d SVA fails",
               tests_ok, tests_bad, checks, errors, u_top_system.u_top_system_chk.fail_count);
      if (errors == 0 && u_top_system.u_top_system_chk.fail_count == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+design
design/tester_pkg.sv
design/reset_sync.sv
design/mem_arbiter.sv
design/shared_mem.sv
design/trap_monitor.sv
design/top_system.sv
test/top_system_chk.sv
test/tb_top_system.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build tb_top_system with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_top_system -f flist.f --Mdir obj_dir \
   || { echo "Verilator build failed"; exit 1; }

sim_out="$(./obj_dir/Vtb_top_system 2>&1)"
echo "$sim_out"
echo "$sim_out" | grep -qx "TESTBENCH PASSED" && exit 0 || exit 1
